// File: flow_table_consts.svh
`ifndef FLOW_TABLE_CONSTS_SVH
`define FLOW_TABLE_CONSTS_SVH

// Table geometry
`define FT_WAYS         4
`define FT_AWIDTH       4
`define FT_DEPTH        (1 << `FT_AWIDTH)

// Field widths
`define TUPLE_WIDTH     32
`define QUEUE_WIDTH     8
`define PKT_LEN_WIDTH   16

// Register stages in each hash pipe
`define HASH_STAGES     2

// All-ones queue id marks a dropped packet
`define QUEUE_DROP      {(`QUEUE_WIDTH){1'b1}}

`endif

// File: flow_table_pkg.sv
`default_nettype none

`include "flow_table_consts.svh"

package flow_table_pkg;

    typedef logic [`TUPLE_WIDTH-1:0] tuple_t;
    typedef logic [`QUEUE_WIDTH-1:0] queue_id_t;
    typedef logic [`FT_AWIDTH-1:0]   way_idx_t;
    typedef way_idx_t [`FT_WAYS-1:0] way_addr_t;
    typedef logic [`FT_WAYS-1:0]     way_mask_t;

    typedef struct packed {
        logic      valid;
        tuple_t    tuple;
        queue_id_t queue_id;
    } fce_t;

    typedef fce_t [`FT_WAYS-1:0] way_fce_t;

    typedef struct packed {
        tuple_t                   tuple;
        queue_id_t                queue_id;
        logic [`PKT_LEN_WIDTH-1:0] pkt_len;
    } metadata_t;

    typedef struct packed {
        tuple_t    tuple;
        queue_id_t queue_id;
    } ctrl_req_t;

    typedef enum logic [1:0] {
        STATUS_UPDATED,
        STATUS_INSERTED,
        STATUS_FULL
    } place_status_t;

    // Ways holding a valid copy of the tuple
    function automatic way_mask_t way_hit(way_fce_t entries, tuple_t tuple);
        way_mask_t hit;
        for (int w = 0; w < `FT_WAYS; w++) begin
            hit[w] = entries[w].valid && (entries[w].tuple == tuple);
        end
        return hit;
    endfunction

    // Lowest set bit only, so way 0 wins
    function automatic way_mask_t first_way(way_mask_t mask);
        return mask & (~mask + 1'b1);
    endfunction

endpackage

`default_nettype wire

// File: flow_hash_pipe.sv
`default_nettype none

`include "flow_table_consts.svh"

module flow_hash_pipe
    import flow_table_pkg::*;
#(
    parameter type payload_t = metadata_t
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  logic      in_valid,
    input  payload_t  in_payload,
    input  tuple_t    in_tuple,
    output logic      hashed_valid,
    output way_addr_t hashed_addr,
    output payload_t  out_payload
);

    localparam int CHUNKS = `TUPLE_WIDTH / `FT_AWIDTH;
    localparam int HALF   = CHUNKS / 2;

    logic [`HASH_STAGES-1:0] vld;
    payload_t                pay [`HASH_STAGES];
    way_addr_t               lo_fold;
    way_addr_t               hi_fold;
    way_addr_t               lo_q;
    way_addr_t               hi_q;
    way_addr_t               addr_q [1:`HASH_STAGES-1];

    function automatic way_idx_t rotl(way_idx_t v, int unsigned n);
        return way_idx_t'((v << n) | (v >> (`FT_AWIDTH - n)));
    endfunction

    // Low and high halves of the tuple folded separately in the first stage
    always_comb begin
        for (int w = 0; w < `FT_WAYS; w++) begin
            lo_fold[w] = '0;
            hi_fold[w] = '0;
            for (int c = 0; c < HALF; c++) begin
                lo_fold[w] = lo_fold[w] ^ rotl(in_tuple[c*`FT_AWIDTH +: `FT_AWIDTH], w);
                hi_fold[w] = hi_fold[w]
                             ^ rotl(in_tuple[(c+HALF)*`FT_AWIDTH +: `FT_AWIDTH], w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else if (!stall) begin
            vld <= {vld[`HASH_STAGES-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pay[0] <= in_payload;
            lo_q   <= lo_fold;
            hi_q   <= hi_fold;
            for (int i = 1; i < `HASH_STAGES; i++) begin
                pay[i] <= pay[i-1];
            end
            addr_q[1] <= lo_q ^ hi_q;
            for (int i = 2; i < `HASH_STAGES; i++) begin
                addr_q[i] <= addr_q[i-1];
            end
        end
    end

    assign hashed_valid = vld[`HASH_STAGES-1];
    assign hashed_addr  = addr_q[`HASH_STAGES-1];
    assign out_payload  = pay[`HASH_STAGES-1];

endmodule

`default_nettype wire

// File: flow_subtable_bank.sv
`default_nettype none

`include "flow_table_consts.svh"

module flow_subtable_bank
    import flow_table_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      a_rd,
    input  logic      a_hold,
    input  way_addr_t a_addr,
    output way_fce_t  a_q,
    input  logic      b_rd,
    input  way_mask_t b_wr,
    input  way_addr_t b_addr,
    input  fce_t      b_data,
    output way_fce_t  b_q
);

    logic a_rd_r;
    logic b_rd_r;

    // Read strobes shared by all ways
    always_ff @(posedge clk) begin
        if (rst) begin
            a_rd_r <= 1'b0;
            b_rd_r <= 1'b0;
        end else begin
            if (!a_hold) begin
                a_rd_r <= a_rd;
            end
            b_rd_r <= b_rd;
        end
    end

    for (genvar w = 0; w < `FT_WAYS; w++) begin : g_way
        logic [$bits(fce_t)-2:0] mem [`FT_DEPTH];
        logic [`FT_DEPTH-1:0]    vld;
        way_idx_t                a_addr_r;
        way_idx_t                b_addr_r;
        fce_t                    a_q_r;
        fce_t                    b_q_r;

        // Tuple and queue id only, valid kept in flops
        always_ff @(posedge clk) begin
            if (b_wr[w]) begin
                mem[b_addr[w]] <= {b_data.tuple, b_data.queue_id};
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                vld <= '0;
            end else if (b_wr[w]) begin
                vld[b_addr[w]] <= b_data.valid;
            end
        end

        // Port A freezes with the service pipeline
        always_ff @(posedge clk) begin
            if (!a_hold) begin
                if (a_rd) begin
                    a_addr_r <= a_addr[w];
                end
                if (a_rd_r) begin
                    a_q_r <= {vld[a_addr_r], mem[a_addr_r]};
                end
            end
        end

        always_ff @(posedge clk) begin
            if (b_rd) begin
                b_addr_r <= b_addr[w];
            end
            if (b_rd_r) begin
                b_q_r <= {vld[b_addr_r], mem[b_addr_r]};
            end
        end

        assign a_q[w] = a_q_r;
        assign b_q[w] = b_q_r;
    end

endmodule

`default_nettype wire

// File: flow_lookup_pipe.sv
`default_nettype none

`include "flow_table_consts.svh"

module flow_lookup_pipe
    import flow_table_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      hashed_valid,
    input  way_addr_t hashed_addr,
    input  metadata_t in_meta,
    output logic      a_rd,
    output logic      a_hold,
    output way_addr_t a_addr,
    input  way_fce_t  a_q,
    input  logic      out_meta_ready,
    output metadata_t out_meta,
    output logic      out_meta_valid
);

    logic      rd_v1;
    logic      rd_v2;
    metadata_t meta_r0;
    metadata_t meta_r1;
    metadata_t meta_r2;
    way_mask_t hit;
    way_mask_t sel;
    queue_id_t hit_queue;
    metadata_t result;

    // Downstream back-pressure freezes every service stage
    assign a_hold = !out_meta_ready;

    always_comb begin
        hit       = way_hit(a_q, meta_r2.tuple);
        sel       = first_way(hit);
        hit_queue = '0;
        for (int w = 0; w < `FT_WAYS; w++) begin
            if (sel[w]) begin
                hit_queue = a_q[w].queue_id;
            end
        end
        result          = meta_r2;
        result.queue_id = (hit != '0) ? hit_queue : queue_id_t'(`QUEUE_DROP);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a_rd           <= 1'b0;
            rd_v1          <= 1'b0;
            rd_v2          <= 1'b0;
            out_meta_valid <= 1'b0;
        end else if (!a_hold) begin
            a_rd           <= hashed_valid;
            rd_v1          <= a_rd;
            rd_v2          <= rd_v1;
            out_meta_valid <= rd_v2;
        end
    end

    // Metadata rides alongside the two-cycle bank read
    always_ff @(posedge clk) begin
        if (!a_hold) begin
            if (hashed_valid) begin
                a_addr <= hashed_addr;
            end
            meta_r0 <= in_meta;
            meta_r1 <= meta_r0;
            meta_r2 <= meta_r1;
            if (rd_v2) begin
                out_meta <= result;
            end
        end
    end

endmodule

`default_nettype wire

// File: flow_place_ctrl.sv
`default_nettype none

`include "flow_table_consts.svh"

module flow_place_ctrl
    import flow_table_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          req_accept,
    input  logic          hashed_valid,
    input  way_addr_t     hashed_addr,
    input  ctrl_req_t     in_req,
    output logic          busy,
    output logic          b_rd,
    output way_mask_t     b_wr,
    output way_addr_t     b_addr,
    output fce_t          b_data,
    input  way_fce_t      b_q,
    output logic          ctrl_done,
    output place_status_t ctrl_status
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITE,
        S_DONE
    } state_t;

    state_t    state;
    logic [1:0] rd_pipe;
    way_addr_t addr_r;
    fce_t      entry_r;
    way_mask_t hit_r;
    way_mask_t empty_r;
    way_mask_t empty_now;

    assign b_addr    = addr_r;
    assign b_data    = entry_r;
    assign ctrl_done = (state == S_DONE);

    always_comb begin
        for (int w = 0; w < `FT_WAYS; w++) begin
            empty_now[w] = !b_q[w].valid;
        end
    end

    // Update beats insert, nothing written when every way is taken
    always_comb begin
        b_wr = '0;
        if (state == S_WRITE) begin
            b_wr = (hit_r != '0) ? first_way(hit_r) : first_way(empty_r);
        end
    end

    always_comb begin
        if (hit_r != '0) begin
            ctrl_status = STATUS_UPDATED;
        end else if (empty_r != '0) begin
            ctrl_status = STATUS_INSERTED;
        end else begin
            ctrl_status = STATUS_FULL;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            b_rd    <= 1'b0;
            rd_pipe <= '0;
            busy    <= 1'b0;
            hit_r   <= '0;
            empty_r <= '0;
        end else begin
            b_rd    <= 1'b0;
            rd_pipe <= {rd_pipe[0], b_rd};
            if (req_accept) begin
                busy <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (hashed_valid) begin
                        b_rd  <= 1'b1;
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    // Candidates arrive two cycles after the read
                    if (rd_pipe[1]) begin
                        hit_r   <= way_hit(b_q, entry_r.tuple);
                        empty_r <= empty_now;
                        state   <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    busy  <= 1'b0;
                    state <= S_DONE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && hashed_valid) begin
            addr_r           <= hashed_addr;
            entry_r.valid    <= 1'b1;
            entry_r.tuple    <= in_req.tuple;
            entry_r.queue_id <= in_req.queue_id;
        end
    end

endmodule

`default_nettype wire

// File: flow_table_top.sv
`default_nettype none

module flow_table_top
    import flow_table_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    // Service path
    input  metadata_t     in_meta,
    input  logic          in_meta_valid,
    output logic          in_meta_ready,
    output metadata_t     out_meta,
    output logic          out_meta_valid,
    input  logic          out_meta_ready,
    // Placement path
    input  ctrl_req_t     in_ctrl,
    input  logic          in_ctrl_valid,
    output logic          in_ctrl_ready,
    output logic          ctrl_done,
    output place_status_t ctrl_status
);

    logic      svc_stall;
    logic      svc_hashed_valid;
    way_addr_t svc_hashed_addr;
    metadata_t svc_meta;

    logic      plc_accept;
    logic      plc_busy;
    logic      plc_hashed_valid;
    way_addr_t plc_hashed_addr;
    ctrl_req_t plc_req;

    logic      a_rd;
    way_addr_t a_addr;
    way_fce_t  a_q;
    logic      b_rd;
    way_mask_t b_wr;
    way_addr_t b_addr;
    fce_t      b_data;
    way_fce_t  b_q;

    assign in_meta_ready = out_meta_ready;
    assign in_ctrl_ready = !plc_busy;
    assign plc_accept    = in_ctrl_valid && in_ctrl_ready;

    flow_hash_pipe #(
        .payload_t (metadata_t)
    ) u_service_hash (
        .clk          (clk),
        .rst          (rst),
        .stall        (svc_stall),
        .in_valid     (in_meta_valid && in_meta_ready),
        .in_payload   (in_meta),
        .in_tuple     (in_meta.tuple),
        .hashed_valid (svc_hashed_valid),
        .hashed_addr  (svc_hashed_addr),
        .out_payload  (svc_meta)
    );

    // Only one request in flight, so this pipe never has to hold
    flow_hash_pipe #(
        .payload_t (ctrl_req_t)
    ) u_place_hash (
        .clk          (clk),
        .rst          (rst),
        .stall        (1'b0),
        .in_valid     (plc_accept),
        .in_payload   (in_ctrl),
        .in_tuple     (in_ctrl.tuple),
        .hashed_valid (plc_hashed_valid),
        .hashed_addr  (plc_hashed_addr),
        .out_payload  (plc_req)
    );

    flow_subtable_bank u_bank (
        .clk    (clk),
        .rst    (rst),
        .a_rd   (a_rd),
        .a_hold (svc_stall),
        .a_addr (a_addr),
        .a_q    (a_q),
        .b_rd   (b_rd),
        .b_wr   (b_wr),
        .b_addr (b_addr),
        .b_data (b_data),
        .b_q    (b_q)
    );

    flow_lookup_pipe u_lookup (
        .clk            (clk),
        .rst            (rst),
        .hashed_valid   (svc_hashed_valid),
        .hashed_addr    (svc_hashed_addr),
        .in_meta        (svc_meta),
        .a_rd           (a_rd),
        .a_hold         (svc_stall),
        .a_addr         (a_addr),
        .a_q            (a_q),
        .out_meta_ready (out_meta_ready),
        .out_meta       (out_meta),
        .out_meta_valid (out_meta_valid)
    );

    flow_place_ctrl u_place (
        .clk          (clk),
        .rst          (rst),
        .req_accept   (plc_accept),
        .hashed_valid (plc_hashed_valid),
        .hashed_addr  (plc_hashed_addr),
        .in_req       (plc_req),
        .busy         (plc_busy),
        .b_rd         (b_rd),
        .b_wr         (b_wr),
        .b_addr       (b_addr),
        .b_data       (b_data),
        .b_q          (b_q),
        .ctrl_done    (ctrl_done),
        .ctrl_status  (ctrl_status)
    );

endmodule

`default_nettype wire

// File: flow_table_asserts.sv
`default_nettype none

module flow_table_asserts
    import flow_table_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input metadata_t out_meta,
    input logic      out_meta_valid,
    input logic      out_meta_ready,
    input logic      in_ctrl_valid,
    input logic      in_ctrl_ready,
    input logic      ctrl_done
);

    int fail_count = 0;

    // Output held while the downstream stalls
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_meta_valid && !out_meta_ready |=> out_meta_valid && $stable(out_meta))
    else begin
        $error("out_meta changed while out_meta_ready was low");
        fail_count++;
    end

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        ctrl_done |=> !ctrl_done)
    else begin
        $error("ctrl_done lasted more than one cycle");
        fail_count++;
    end

    // Busy from acceptance until the done edge
    ctrl_busy: assert property (@(posedge clk) disable iff (rst)
        in_ctrl_valid && in_ctrl_ready |=> !in_ctrl_ready)
    else begin
        $error("in_ctrl_ready stayed high after acceptance");
        fail_count++;
    end

    ctrl_release: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ctrl_ready) |-> ctrl_done)
    else begin
        $error("in_ctrl_ready rose without ctrl_done");
        fail_count++;
    end

    reset_state: assert property (@(posedge clk)
        rst |=> !out_meta_valid && !ctrl_done && in_ctrl_ready)
    else begin
        $error("outputs not idle after reset");
        fail_count++;
    end

endmodule

bind flow_table_top flow_table_asserts u_asserts (
    .clk            (clk),
    .rst            (rst),
    .out_meta       (out_meta),
    .out_meta_valid (out_meta_valid),
    .out_meta_ready (out_meta_ready),
    .in_ctrl_valid  (in_ctrl_valid),
    .in_ctrl_ready  (in_ctrl_ready),
    .ctrl_done      (ctrl_done)
);

`default_nettype wire

// File: flow_table_tb.sv
`default_nettype none

`include "flow_table_consts.svh"

module flow_table_tb
    import flow_table_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    // Cycle budget with a fourfold margin for stalls
    localparam int NUM_PLACES   = 14;
    localparam int PLACE_CYCLES = 12;
    localparam int NUM_LOOKUPS  = 31;
    localparam int NUM_BURSTS   = 5;
    localparam int BURST_FILL   = 10;
    localparam int MAX_CYCLES   = 4 * (2 * RESET_CYCLES + NUM_PLACES * PLACE_CYCLES
                                       + NUM_LOOKUPS + NUM_BURSTS * BURST_FILL);

    logic          clk = 1'b0;
    logic          rst;
    metadata_t     in_meta;
    logic          in_meta_valid;
    logic          in_meta_ready;
    metadata_t     out_meta;
    logic          out_meta_valid;
    logic          out_meta_ready;
    ctrl_req_t     in_ctrl;
    logic          in_ctrl_valid;
    logic          in_ctrl_ready;
    logic          ctrl_done;
    place_status_t ctrl_status;

    int   seed = 32'ha7f4;
    int   cycles = 0;
    logic timed_out = 1'b0;
    int   queue_errors = 0;
    int   status_errors = 0;
    int   meta_errors = 0;

    // Reference table
    logic      m_valid [`FT_WAYS][`FT_DEPTH];
    tuple_t    m_tuple [`FT_WAYS][`FT_DEPTH];
    queue_id_t m_queue [`FT_WAYS][`FT_DEPTH];

    tuple_t    flow_tuple [8];
    queue_id_t flow_queue [8];
    tuple_t    pair_tuple [5];
    tuple_t    look_q [$];

    flow_table_top u_flow_table_top (
        .clk            (clk),
        .rst            (rst),
        .in_meta        (in_meta),
        .in_meta_valid  (in_meta_valid),
        .in_meta_ready  (in_meta_ready),
        .out_meta       (out_meta),
        .out_meta_valid (out_meta_valid),
        .out_meta_ready (out_meta_ready),
        .in_ctrl        (in_ctrl),
        .in_ctrl_valid  (in_ctrl_valid),
        .in_ctrl_ready  (in_ctrl_ready),
        .ctrl_done      (ctrl_done),
        .ctrl_status    (ctrl_status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            timed_out = 1'b1;
            $display("Timeout: tests did not complete within %0d cycles", MAX_CYCLES);
            finish_run();
        end
    end

    // Each chunk rotated left by the way number and folded by XOR
    function automatic way_idx_t index_of(tuple_t t, int w);
        logic [2*`FT_AWIDTH-1:0] spread;
        way_idx_t                acc;
        acc = '0;
        for (int c = 0; c < `TUPLE_WIDTH / `FT_AWIDTH; c++) begin
            spread = {{`FT_AWIDTH{1'b0}}, t[c*`FT_AWIDTH +: `FT_AWIDTH]} << w;
            acc = acc ^ spread[`FT_AWIDTH-1:0] ^ spread[2*`FT_AWIDTH-1:`FT_AWIDTH];
        end
        return acc;
    endfunction

    function automatic queue_id_t predict_queue(tuple_t t);
        way_idx_t  idx;
        queue_id_t q;
        logic      found;
        q = `QUEUE_DROP;
        found = 1'b0;
        for (int w = 0; w < `FT_WAYS; w++) begin
            idx = index_of(t, w);
            if (!found && m_valid[w][idx] && m_tuple[w][idx] == t) begin
                q = m_queue[w][idx];
                found = 1'b1;
            end
        end
        return q;
    endfunction

    // Writes the lowest hit, or the lowest empty way if any
    task automatic model_place(input tuple_t t, input queue_id_t q);
        way_idx_t idx;
        int       target;
        target = -1;
        for (int w = 0; w < `FT_WAYS; w++) begin
            idx = index_of(t, w);
            if (target < 0 && m_valid[w][idx] && m_tuple[w][idx] == t) begin
                target = w;
            end
        end
        for (int w = 0; w < `FT_WAYS; w++) begin
            idx = index_of(t, w);
            if (target < 0 && !m_valid[w][idx]) begin
                target = w;
            end
        end
        if (target >= 0) begin
            idx = index_of(t, target);
            m_valid[target][idx] = 1'b1;
            m_tuple[target][idx] = t;
            m_queue[target][idx] = q;
        end
    endtask

    task automatic compare_queue(input string name, input queue_id_t got, input queue_id_t exp);
        if (got !== exp) begin
            queue_errors++;
            $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_status(input string name, input place_status_t got,
                                  input place_status_t exp);
        if (got !== exp) begin
            status_errors++;
            $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_meta(input string name, input metadata_t got, input metadata_t exp);
        if (got.tuple !== exp.tuple || got.pkt_len !== exp.pkt_len) begin
            meta_errors++;
            $display("** Error: %s got tuple 0x%h len 0x%h expected tuple 0x%h len 0x%h",
                     name, got.tuple, got.pkt_len, exp.tuple, exp.pkt_len);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        in_meta = '0;
        in_meta_valid = 1'b0;
        out_meta_ready = 1'b1;
        in_ctrl = '0;
        in_ctrl_valid = 1'b0;
        for (int w = 0; w < `FT_WAYS; w++) begin
            for (int i = 0; i < `FT_DEPTH; i++) begin
                m_valid[w][i] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic place_flow(input tuple_t t, input queue_id_t q, input place_status_t exp);
        @(negedge clk);
        in_ctrl.tuple = t;
        in_ctrl.queue_id = q;
        in_ctrl_valid = 1'b1;
        while (!in_ctrl_ready) @(negedge clk);
        @(negedge clk);
        in_ctrl_valid = 1'b0;
        while (!ctrl_done) @(negedge clk);
        compare_status("ctrl_status", ctrl_status, exp);
        model_place(t, q);
    endtask

    // Sends every tuple in look_q and checks the results in order
    task automatic run_lookups(input logic backpressure);
        metadata_t   items [$];
        metadata_t   expect_q [$];
        metadata_t   item;
        logic [31:0] rnd;
        int          sent;
        int          recv;
        foreach (look_q[i]) begin
            rnd = $random(seed);
            item.tuple = look_q[i];
            item.queue_id = rnd[31:24];
            item.pkt_len = rnd[15:0];
            items.push_back(item);
            item.queue_id = predict_queue(look_q[i]);
            expect_q.push_back(item);
        end
        sent = 0;
        recv = 0;
        while (recv < items.size()) begin
            @(negedge clk);
            rnd = $random(seed);
            out_meta_ready = backpressure ? rnd[0] : 1'b1;
            in_meta_valid = (sent < items.size());
            if (sent < items.size()) begin
                in_meta = items[sent];
            end
            #1;
            if (out_meta_valid && out_meta_ready) begin
                compare_queue("out_meta.queue_id", out_meta.queue_id, expect_q[recv].queue_id);
                compare_meta("out_meta", out_meta, expect_q[recv]);
                recv++;
            end
            if (in_meta_valid && in_meta_ready) begin
                sent++;
            end
        end
        @(negedge clk);
        in_meta_valid = 1'b0;
        out_meta_ready = 1'b1;
    endtask

    task automatic test_empty_lookup();
        logic [31:0] rnd;
        $display("Test 1: lookup on an empty table");
        rnd = $random(seed);
        look_q.delete();
        look_q.push_back(rnd);
        run_lookups(1'b0);
    endtask

    task automatic test_insert_random();
        logic [31:0] rnd;
        $display("Test 2: insert eight random flows");
        look_q.delete();
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            flow_tuple[i] = rnd;
            rnd = $random(seed);
            flow_queue[i] = {1'b0, rnd[6:0]};
            place_flow(flow_tuple[i], flow_queue[i], STATUS_INSERTED);
            look_q.push_back(flow_tuple[i]);
        end
        run_lookups(1'b0);
    endtask

    task automatic test_update();
        $display("Test 3: update an existing flow");
        flow_queue[3] = flow_queue[3] ^ 8'h01;
        place_flow(flow_tuple[3], flow_queue[3], STATUS_UPDATED);
        look_q.delete();
        look_q.push_back(flow_tuple[3]);
        run_lookups(1'b0);
    endtask

    task automatic test_full_way();
        $display("Test 4: five flows on index 0 of every way");
        apply_reset();
        pair_tuple[0] = 32'h1122_3344;
        pair_tuple[1] = 32'h5566_7788;
        pair_tuple[2] = 32'h99aa_bbcc;
        pair_tuple[3] = 32'hddee_ff00;
        pair_tuple[4] = 32'h1212_3434;
        look_q.delete();
        for (int i = 0; i < 5; i++) begin
            place_flow(pair_tuple[i], queue_id_t'(8'h20 + i),
                       (i < 4) ? STATUS_INSERTED : STATUS_FULL);
            look_q.push_back(pair_tuple[i]);
        end
        run_lookups(1'b0);
    endtask

    task automatic test_backpressure();
        logic [31:0] rnd;
        $display("Test 5: lookup burst under random back-pressure");
        look_q.delete();
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            look_q.push_back((i % 6 == 5) ? tuple_t'(rnd) : pair_tuple[i % 6]);
        end
        run_lookups(1'b1);
    endtask

    task automatic finish_run();
        int assert_errors;
        int total;
        assert_errors = u_flow_table_top.u_asserts.fail_count;
        total = queue_errors + status_errors + meta_errors + assert_errors;
        if (timed_out) begin
            total++;
        end
        $display("Errors: queue id %0d, status %0d, packet %0d, assertions %0d",
                 queue_errors, status_errors, meta_errors, assert_errors);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        apply_reset();
        test_empty_lookup();
        test_insert_random();
        test_update();
        test_full_way();
        test_backpressure();
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

// File: flow_table.f
+incdir+.
flow_table_pkg.sv
flow_hash_pipe.sv
flow_subtable_bank.sv
flow_lookup_pipe.sv
flow_place_ctrl.sv
flow_table_top.sv
flow_table_asserts.sv
flow_table_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module flow_table_tb \
    -f flow_table.f -o flow_table_sim \
    && ./obj_dir/flow_table_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^Simulation passed$" sim.log && exit 0 || exit 1
